// ==== verilog/isaPkg.sv ====
// Instruction set package: field positions, register count, opcode values
package isaPkg;

   // Opcode field, bits 31 to 27
   localparam int opcodeLsb = 27;
   localparam int opcodeBits = 5;

   // Register fields, 4 bits each
   localparam int raLsb = 23;
   localparam int rbLsb = 19;
   localparam int rcLsb = 15;

   localparam int regIdxBits = 4;
   localparam int numRegs = 16;

   // Immediate C field, bits 18 to 0
   localparam int constBits = 19;

   // Load immediate: ra <- rb + C, or C alone when rb is R0
   localparam logic [opcodeBits-1:0] opLdi = 5'b00001;

endpackage

// ==== verilog/datapathPkg.sv ====
// Datapath package: word width, ALU operation codes, register reset value
package datapathPkg;

   localparam int wordBits = 32;

   // ALU operation select
   localparam int aluOpBits = 3;

   localparam logic [aluOpBits-1:0] aluAdd = 3'd0;
   localparam logic [aluOpBits-1:0] aluSub = 3'd1;
   localparam logic [aluOpBits-1:0] aluAnd = 3'd2;
   localparam logic [aluOpBits-1:0] aluOr  = 3'd3;
   localparam logic [aluOpBits-1:0] aluShl = 3'd4;
   localparam logic [aluOpBits-1:0] aluShr = 3'd5;
   // Unary ops, bus operand only
   localparam logic [aluOpBits-1:0] aluNeg = 3'd6;
   localparam logic [aluOpBits-1:0] aluNot = 3'd7;

   // Value of every datapath register after reset
   localparam logic [wordBits-1:0] regResetValue = '0;

endpackage

// ==== verilog/selectEncode.sv ====
// Register select and encode logic: IR field pick, write decode, base-address zero, C extend
`timescale 1ns/1ns

module selectEncode (
   input  logic [datapathPkg::wordBits-1:0]  ir,
   input  logic                              gra,
   input  logic                              grb,
   input  logic                              grc,
   input  logic                              rIn,
   input  logic                              rOut,
   input  logic                              baOut,
   output logic [isaPkg::numRegs-1:0]        regWrite,
   output logic [isaPkg::regIdxBits-1:0]     regIdx,
   output logic                              regOutEn,
   output logic                              baZero,
   output logic [datapathPkg::wordBits-1:0]  constExt
);

   logic [isaPkg::regIdxBits-1:0] selIdx;
   logic [isaPkg::numRegs-1:0]    oneHot;
   logic                          anySel;

   assign anySel = gra | grb | grc;

   // Field choice, ra first if more than one is raised
   always_comb begin
      selIdx = '0;
      if (gra) begin
         selIdx = ir[isaPkg::raLsb +: isaPkg::regIdxBits];
      end else if (grb) begin
         selIdx = ir[isaPkg::rbLsb +: isaPkg::regIdxBits];
      end else if (grc) begin
         selIdx = ir[isaPkg::rcLsb +: isaPkg::regIdxBits];
      end
   end

   assign oneHot   = {{(isaPkg::numRegs-1){1'b0}}, 1'b1} << selIdx;
   assign regWrite = (rIn && anySel) ? oneHot : '0;
   assign regIdx   = selIdx;

   // R0 reads as zero only as a base address
   assign baZero   = baOut && anySel && (selIdx == '0);
   assign regOutEn = (rOut || baOut) && anySel && !baZero;

   assign constExt = {{(datapathPkg::wordBits-isaPkg::constBits){ir[isaPkg::constBits-1]}},
                      ir[isaPkg::constBits-1:0]};

endmodule

// ==== verilog/registerFile.sv ====
// General register file: 16 slots with one-hot write and indexed read
`timescale 1ns/1ns

module registerFile (
   input  logic                              Clock,
   input  logic                              arstN,
   input  logic [isaPkg::numRegs-1:0]        regWrite,
   input  logic [isaPkg::regIdxBits-1:0]     regIdx,
   input  logic [datapathPkg::wordBits-1:0]  busValue,
   output logic [datapathPkg::wordBits-1:0]  regValue
);

   logic [datapathPkg::wordBits-1:0] slotValue [isaPkg::numRegs];

   // One register per slot, loaded from the bus
   for (genvar i = 0; i < isaPkg::numRegs; i++) begin : gSlot
      logic [datapathPkg::wordBits-1:0] slotQ;

      always_ff @(posedge Clock or negedge arstN) begin
         if (!arstN) begin
            slotQ <= datapathPkg::regResetValue;
         end else if (regWrite[i]) begin
            slotQ <= busValue;
         end
      end

      assign slotValue[i] = slotQ;
   end

   // Read side, gated onto the bus by busMux
   assign regValue = slotValue[regIdx];

endmodule

// ==== verilog/busMux.sv ====
// Shared bus multiplexer: priority pick of one source from the out strobes
`timescale 1ns/1ns

module busMux (
   input  logic [datapathPkg::wordBits-1:0]  regValue,
   input  logic                              regOutEn,
   input  logic                              baZero,
   input  logic [datapathPkg::wordBits-1:0]  pcValue,
   input  logic                              pcOut,
   input  logic [datapathPkg::wordBits-1:0]  zValue,
   input  logic                              zOut,
   input  logic [datapathPkg::wordBits-1:0]  mdrValue,
   input  logic                              mdrOut,
   input  logic [datapathPkg::wordBits-1:0]  inportData,
   input  logic                              inportOut,
   input  logic [datapathPkg::wordBits-1:0]  constExt,
   input  logic                              cOut,
   output logic [datapathPkg::wordBits-1:0]  busValue
);

   // Lowest source in the list wins, idle bus is zero
   always_comb begin
      if (baZero) begin
         // R0 as base address
         busValue = '0;
      end else if (regOutEn) begin
         busValue = regValue;
      end else if (pcOut) begin
         busValue = pcValue;
      end else if (zOut) begin
         busValue = zValue;
      end else if (mdrOut) begin
         busValue = mdrValue;
      end else if (inportOut) begin
         busValue = inportData;
      end else if (cOut) begin
         busValue = constExt;
      end else begin
         busValue = '0;
      end
   end

endmodule

// ==== verilog/alu.sv ====
// Single-cycle ALU on Y and the bus, result held in Z
`timescale 1ns/1ns

module alu (
   input  logic                                Clock,
   input  logic                                arstN,
   input  logic [datapathPkg::aluOpBits-1:0]   aluOp,
   input  logic [datapathPkg::wordBits-1:0]    yValue,
   input  logic [datapathPkg::wordBits-1:0]    busValue,
   input  logic                                zIn,
   output logic [datapathPkg::wordBits-1:0]    zValue
);

   localparam int shiftBits = $clog2(datapathPkg::wordBits);

   logic [datapathPkg::wordBits-1:0] result;
   logic [shiftBits-1:0]             shiftAmount;

   // Shift count from the low bits of operand B
   assign shiftAmount = busValue[shiftBits-1:0];

   always_comb begin
      case (aluOp)
         datapathPkg::aluAdd: result = yValue + busValue;
         datapathPkg::aluSub: result = yValue - busValue;
         datapathPkg::aluAnd: result = yValue & busValue;
         datapathPkg::aluOr:  result = yValue | busValue;
         datapathPkg::aluShl: result = yValue << shiftAmount;
         // Logical shift, zero fill
         datapathPkg::aluShr: result = yValue >> shiftAmount;
         datapathPkg::aluNeg: result = -busValue;
         datapathPkg::aluNot: result = ~busValue;
         default:             result = '0;
      endcase
   end

   // Z register
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         zValue <= datapathPkg::regResetValue;
      end else if (zIn) begin
         zValue <= result;
      end
   end

endmodule

// ==== verilog/memoryInterface.sv ====
// Memory interface: MAR, MDR and the word RAM
`timescale 1ns/1ns

module memoryInterface #(
   parameter int memAddrBits = 9
) (
   input  logic                              Clock,
   input  logic                              arstN,
   input  logic [datapathPkg::wordBits-1:0]  busValue,
   input  logic                              marIn,
   input  logic                              mdrIn,
   input  logic                              read,
   input  logic                              write,
   output logic [datapathPkg::wordBits-1:0]  mdrValue
);

   localparam int memWords = 2 ** memAddrBits;

   logic [memAddrBits-1:0]           mar;
   logic [datapathPkg::wordBits-1:0] mdr;
   logic [datapathPkg::wordBits-1:0] ram [memWords];

   // Only the low address bits are kept
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         mar <= '0;
      end else if (marIn) begin
         mar <= busValue[memAddrBits-1:0];
      end
   end

   // MDR source is RAM during a read, the bus otherwise
   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         mdr <= datapathPkg::regResetValue;
      end else if (mdrIn) begin
         mdr <= read ? ram[mar] : busValue;
      end
   end

   // Write stores the MDR contents at MAR
   always_ff @(posedge Clock) begin
      if (write) begin
         ram[mar] <= mdr;
      end
   end

   assign mdrValue = mdr;

endmodule

// ==== verilog/programRegisters.sv ====
// Program registers: PC with increment, IR, Y and the output port
`timescale 1ns/1ns

module programRegisters (
   input  logic                              Clock,
   input  logic                              arstN,
   input  logic [datapathPkg::wordBits-1:0]  busValue,
   input  logic                              pcIn,
   input  logic                              incPc,
   input  logic                              irIn,
   input  logic                              yIn,
   input  logic                              outportIn,
   output logic [datapathPkg::wordBits-1:0]  pcValue,
   output logic [datapathPkg::wordBits-1:0]  irValue,
   output logic [datapathPkg::wordBits-1:0]  yValue,
   output logic [datapathPkg::wordBits-1:0]  outportData
);

   always_ff @(posedge Clock or negedge arstN) begin
      if (!arstN) begin
         pcValue     <= datapathPkg::regResetValue;
         irValue     <= datapathPkg::regResetValue;
         yValue      <= datapathPkg::regResetValue;
         outportData <= datapathPkg::regResetValue;
      end else begin
         // Bus load takes precedence over increment
         if (pcIn) begin
            pcValue <= busValue;
         end else if (incPc) begin
            pcValue <= pcValue + 1'b1;
         end
         if (irIn) begin
            irValue <= busValue;
         end
         if (yIn) begin
            yValue <= busValue;
         end
         if (outportIn) begin
            outportData <= busValue;
         end
      end
   end

endmodule

// ==== verilog/dataPath.sv ====
// Datapath top level: shared bus joining registers, ALU, memory and ports
`timescale 1ns/1ns

module dataPath #(
   parameter int memAddrBits = 9
) (
   input  logic                                Clock,
   input  logic                                arstN,
   input  logic                                gra,
   input  logic                                grb,
   input  logic                                grc,
   input  logic                                rIn,
   input  logic                                rOut,
   input  logic                                baOut,
   input  logic                                pcOut,
   input  logic                                zOut,
   input  logic                                mdrOut,
   input  logic                                inportOut,
   input  logic                                cOut,
   input  logic                                pcIn,
   input  logic                                irIn,
   input  logic                                yIn,
   input  logic                                zIn,
   input  logic                                marIn,
   input  logic                                mdrIn,
   input  logic                                outportIn,
   input  logic                                incPc,
   input  logic                                read,
   input  logic                                write,
   input  logic [datapathPkg::aluOpBits-1:0]   aluOp,
   input  logic [datapathPkg::wordBits-1:0]    inportData,
   output logic [datapathPkg::wordBits-1:0]    outportData
);

   logic [datapathPkg::wordBits-1:0] busValue;
   logic [datapathPkg::wordBits-1:0] regValue;
   logic [datapathPkg::wordBits-1:0] pcValue;
   logic [datapathPkg::wordBits-1:0] irValue;
   logic [datapathPkg::wordBits-1:0] yValue;
   logic [datapathPkg::wordBits-1:0] zValue;
   logic [datapathPkg::wordBits-1:0] mdrValue;
   logic [datapathPkg::wordBits-1:0] constExt;
   logic [isaPkg::numRegs-1:0]       regWrite;
   logic [isaPkg::regIdxBits-1:0]    regIdx;
   logic                             regOutEn;
   logic                             baZero;

   selectEncode selEnc (
      .ir(irValue), .gra(gra), .grb(grb), .grc(grc),
      .rIn(rIn), .rOut(rOut), .baOut(baOut),
      .regWrite(regWrite), .regIdx(regIdx), .regOutEn(regOutEn),
      .baZero(baZero), .constExt(constExt)
   );

   registerFile regFile (
      .Clock(Clock), .arstN(arstN), .regWrite(regWrite), .regIdx(regIdx),
      .busValue(busValue), .regValue(regValue)
   );

   // Bus source select
   busMux bus (
      .regValue(regValue), .regOutEn(regOutEn), .baZero(baZero),
      .pcValue(pcValue), .pcOut(pcOut), .zValue(zValue), .zOut(zOut),
      .mdrValue(mdrValue), .mdrOut(mdrOut),
      .inportData(inportData), .inportOut(inportOut),
      .constExt(constExt), .cOut(cOut), .busValue(busValue)
   );

   alu aluUnit (
      .Clock(Clock), .arstN(arstN), .aluOp(aluOp), .yValue(yValue),
      .busValue(busValue), .zIn(zIn), .zValue(zValue)
   );

   memoryInterface #(.memAddrBits(memAddrBits)) mem (
      .Clock(Clock), .arstN(arstN), .busValue(busValue), .marIn(marIn),
      .mdrIn(mdrIn), .read(read), .write(write), .mdrValue(mdrValue)
   );

   programRegisters progRegs (
      .Clock(Clock), .arstN(arstN), .busValue(busValue),
      .pcIn(pcIn), .incPc(incPc), .irIn(irIn), .yIn(yIn), .outportIn(outportIn),
      .pcValue(pcValue), .irValue(irValue), .yValue(yValue),
      .outportData(outportData)
   );

endmodule

// ==== tb/dataPathTb.sv ====
// Testbench for the bus datapath: random programs, reference model, checks and watchdog
`timescale 1ns/1ns

module dataPathTb;

   localparam int wordBits = datapathPkg::wordBits;
   localparam int memAddrBits = 9;
   localparam int clockPeriod = 4;
   localparam int numMemTests = 20;
   localparam int numLdiTests = 20;
   localparam int numAluTests = 30;
   localparam int numPcTests = 10;
   // Cycles per iteration: memory 6, ldi 12, ALU 25, PC up to 12
   localparam int testCycles = 10 + numMemTests * 6 + numLdiTests * 12 + numAluTests * 25
                               + numPcTests * 12;
   localparam int watchdogNs = testCycles * clockPeriod * 2;

   logic Clock, arstN;
   logic gra, grb, grc, rIn, rOut, baOut, pcOut, zOut, mdrOut, inportOut, cOut;
   logic pcIn, irIn, yIn, zIn, marIn, mdrIn, outportIn, incPc, read, write;
   logic [datapathPkg::aluOpBits-1:0] aluOp;
   logic [wordBits-1:0] inportData, outportData;

   // Reference model state
   logic [wordBits-1:0] regModel [isaPkg::numRegs];
   logic [wordBits-1:0] memModel [2 ** memAddrBits];
   logic [wordBits-1:0] pcModel;

   integer seed;
   int checkCount, errorCount, totalChecks, totalErrors;

   dataPath #(.memAddrBits(memAddrBits)) UUT (.*);

   initial begin
      Clock = 1'b0;
      forever #(clockPeriod / 2) Clock = ~Clock;
   end

   task automatic clearStrobes();
      {gra, grb, grc, rIn, rOut, baOut, pcOut, zOut, mdrOut, inportOut, cOut} = '0;
      {pcIn, irIn, yIn, zIn, marIn, mdrIn, outportIn, incPc, read, write} = '0;
   endtask

   // Strobes set now take effect at the coming edge
   task automatic nextCycle();
      @(posedge Clock);
      #1;
      clearStrobes();
   endtask

   function automatic logic [wordBits-1:0] signExtendC(input logic [isaPkg::constBits-1:0] c);
      return {{(wordBits - isaPkg::constBits){c[isaPkg::constBits-1]}}, c};
   endfunction

   // Operation table: A is Y, B is the bus
   function automatic logic [wordBits-1:0] aluModel(input logic [2:0] op,
                                                    input logic [wordBits-1:0] a,
                                                    input logic [wordBits-1:0] b);
      case (op)
         3'd0: return a + b;
         3'd1: return a - b;
         3'd2: return a & b;
         3'd3: return a | b;
         3'd4: return a << b[4:0];
         3'd5: return a >> b[4:0];
         3'd6: return -b;
         default: return ~b;
      endcase
   endfunction

   // Caller raises the bus source first
   task automatic checkOutport(input string testName, input logic [wordBits-1:0] expected);
      outportIn = 1'b1;
      nextCycle();
      checkCount++;
      assert (outportData === expected) else begin
         $display("FAILED %s expected %h actual %h", testName, expected, outportData);
         errorCount++;
      end
   endtask

   task automatic finishTest(input string testName);
      $display("Test %s finished: %0d checks, %0d errors", testName, checkCount, errorCount);
      totalChecks += checkCount;
      totalErrors += errorCount;
      checkCount = 0;
      errorCount = 0;
   endtask

   task automatic storeWord(input logic [memAddrBits-1:0] addr, input logic [wordBits-1:0] data);
      inportData = wordBits'(addr);
      inportOut = 1'b1;
      marIn = 1'b1;
      nextCycle();
      inportData = data;
      inportOut = 1'b1;
      mdrIn = 1'b1;
      nextCycle();
      write = 1'b1;
      nextCycle();
      memModel[addr] = data;
   endtask

   task automatic loadIrFromInport(input logic [wordBits-1:0] instr);
      inportData = instr;
      inportOut = 1'b1;
      irIn = 1'b1;
      nextCycle();
   endtask

   // Store at addr, point PC there, fetch, execute
   task automatic runLdi(input logic [3:0] ra, input logic [3:0] rb,
                         input logic [isaPkg::constBits-1:0] c,
                         input logic [memAddrBits-1:0] addr);
      logic [wordBits-1:0] instr;
      instr = '0;
      instr[isaPkg::opcodeLsb +: isaPkg::opcodeBits] = isaPkg::opLdi;
      instr[isaPkg::raLsb +: isaPkg::regIdxBits] = ra;
      instr[isaPkg::rbLsb +: isaPkg::regIdxBits] = rb;
      instr[isaPkg::constBits-1:0] = c;
      storeWord(addr, instr);
      inportData = wordBits'(addr);
      inportOut = 1'b1;
      pcIn = 1'b1;
      nextCycle();
      pcModel = wordBits'(addr);
      // Fetch
      pcOut = 1'b1;
      marIn = 1'b1;
      incPc = 1'b1;
      nextCycle();
      pcModel = pcModel + 1;
      read = 1'b1;
      mdrIn = 1'b1;
      nextCycle();
      mdrOut = 1'b1;
      irIn = 1'b1;
      nextCycle();
      // Execute
      grb = 1'b1;
      baOut = 1'b1;
      yIn = 1'b1;
      nextCycle();
      cOut = 1'b1;
      aluOp = 3'd0;
      zIn = 1'b1;
      nextCycle();
      zOut = 1'b1;
      gra = 1'b1;
      rIn = 1'b1;
      nextCycle();
      regModel[ra] = ((rb == 4'd0) ? '0 : regModel[rb]) + signExtendC(c);
   endtask

   initial begin
      #(watchdogNs);
      $display("Watchdog expired after %0d ns before the tests finished", watchdogNs);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      logic [wordBits-1:0] rnd, data, instr, startPc;
      logic [memAddrBits-1:0] addr;
      logic [2:0] op;
      int count;
      seed = 59202;
      checkCount = 0;
      errorCount = 0;
      totalChecks = 0;
      totalErrors = 0;
      clearStrobes();
      aluOp = '0;
      inportData = '0;
      arstN = 1'b0;
      for (int i = 0; i < isaPkg::numRegs; i++) regModel[i] = '0;
      pcModel = '0;
      repeat (5) @(posedge Clock);
      #1;
      arstN = 1'b1;

      // Reset state through the output port
      loadIrFromInport(wordBits'(5) << isaPkg::raLsb);
      gra = 1'b1;
      rOut = 1'b1;
      checkOutport("reset R5", regModel[5]);
      pcOut = 1'b1;
      checkOutport("reset PC", pcModel);
      finishTest("reset");

      for (int i = 0; i < numMemTests; i++) begin
         rnd = $random(seed);
         addr = rnd[memAddrBits-1:0];
         data = $random(seed);
         storeWord(addr, data);
         // Overwrite MDR so the read back is visible
         inportData = ~data;
         inportOut = 1'b1;
         mdrIn = 1'b1;
         nextCycle();
         read = 1'b1;
         mdrIn = 1'b1;
         nextCycle();
         mdrOut = 1'b1;
         checkOutport("memory round trip", memModel[addr]);
      end
      finishTest("memory");

      for (int i = 0; i < numLdiTests; i++) begin
         rnd = $random(seed);
         runLdi(rnd[3:0], rnd[7:4], rnd[26:8], rnd[31:23]);
         gra = 1'b1;
         rOut = 1'b1;
         checkOutport("ldi", regModel[rnd[3:0]]);
         // PC has stepped past the fetched word
         pcOut = 1'b1;
         checkOutport("ldi pc", pcModel);
      end
      finishTest("ldi");

      for (int i = 0; i < numAluTests; i++) begin
         rnd = $random(seed);
         op = rnd[14:12];
         runLdi(rnd[7:4], 4'd0, rnd[31:13], rnd[8:0]);
         data = $random(seed);
         runLdi(rnd[11:8], 4'd0, data[18:0], data[27:19]);
         instr = '0;
         instr[isaPkg::opcodeLsb +: isaPkg::opcodeBits] = {2'b00, op};
         instr[isaPkg::raLsb +: isaPkg::regIdxBits] = rnd[3:0];
         instr[isaPkg::rbLsb +: isaPkg::regIdxBits] = rnd[7:4];
         instr[isaPkg::rcLsb +: isaPkg::regIdxBits] = rnd[11:8];
         loadIrFromInport(instr);
         grb = 1'b1;
         rOut = 1'b1;
         yIn = 1'b1;
         nextCycle();
         grc = 1'b1;
         rOut = 1'b1;
         aluOp = op;
         zIn = 1'b1;
         nextCycle();
         zOut = 1'b1;
         gra = 1'b1;
         rIn = 1'b1;
         nextCycle();
         regModel[rnd[3:0]] = aluModel(op, regModel[rnd[7:4]], regModel[rnd[11:8]]);
         gra = 1'b1;
         rOut = 1'b1;
         checkOutport("alu", regModel[rnd[3:0]]);
      end
      finishTest("alu");

      for (int i = 0; i < numPcTests; i++) begin
         startPc = $random(seed);
         rnd = $random(seed);
         count = 1 + int'(rnd[15:0] % 10);
         inportData = startPc;
         inportOut = 1'b1;
         pcIn = 1'b1;
         nextCycle();
         repeat (count) begin
            incPc = 1'b1;
            nextCycle();
         end
         pcOut = 1'b1;
         checkOutport("pc increment", startPc + wordBits'(count));
      end
      finishTest("pc increment");

      $display("Totals: %0d checks, %0d errors", totalChecks, totalErrors);
      if (totalErrors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== files.f ====
verilog/isaPkg.sv
verilog/datapathPkg.sv
verilog/selectEncode.sv
verilog/registerFile.sv
verilog/busMux.sv
verilog/alu.sv
verilog/memoryInterface.sv
verilog/programRegisters.sv
verilog/dataPath.sv
tb/dataPathTb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module dataPathTb -f files.f \
   -o simDataPath > build.log 2>&1 \
   && ./obj_dir/simDataPath > sim.log 2>&1 \
   || { cat build.log; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && { echo "Result: FAIL"; exit 1; } || { echo "Result: PASS"; exit 0; }
